// ==== Makefile ====
# Verilator build and run for the AXI-Lite write subsystem testbench

VERILATOR ?= verilator
TOP       ?= axil_wr_subsystem_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== axil_wr_router/axil_wr_join.sv ====
`timescale 1ns/1ps

module axil_wr_join
  import axil_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       s_axil_awvalid,
  input  axil_addr_t s_axil_awaddr,
  output logic       s_axil_awready,

  input  logic       s_axil_wvalid,
  input  axil_data_t s_axil_wdata,
  input  axil_strb_t s_axil_wstrb,
  output logic       s_axil_wready,

  output logic       req_valid,
  output axil_addr_t req_addr,
  output axil_data_t req_data,
  output axil_strb_t req_strb,
  input  logic       req_ready
);

  logic       aw_full;
  logic       w_full;
  axil_addr_t aw_addr_q;
  axil_data_t w_data_q;
  axil_strb_t w_strb_q;
  logic       req_taken;

  // Each channel accepts a beat only while its own hold is empty
  assign s_axil_awready = ~aw_full;
  assign s_axil_wready  = ~w_full;

  assign req_valid = aw_full & w_full;
  assign req_taken = req_valid & req_ready;

  assign req_addr = aw_addr_q;
  assign req_data = w_data_q;
  assign req_strb = w_strb_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
    end else begin
      // A hold is never loaded and freed in the same cycle
      if (s_axil_awvalid && s_axil_awready) begin
        aw_full <= 1'b1;
      end else if (req_taken) begin
        aw_full <= 1'b0;
      end
      if (s_axil_wvalid && s_axil_wready) begin
        w_full <= 1'b1;
      end else if (req_taken) begin
        w_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s_axil_awvalid && s_axil_awready) begin
      aw_addr_q <= s_axil_awaddr;
    end
    if (s_axil_wvalid && s_axil_wready) begin
      w_data_q <= s_axil_wdata;
      w_strb_q <= s_axil_wstrb;
    end
  end

endmodule

// ==== axil_wr_router/axil_wr_router.sv ====
`timescale 1ns/1ps

module axil_wr_router
  import axil_pkg::*;
#(
  parameter int NUM_S = 3
) (
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         req_valid,
  input  axil_addr_t                   req_addr,
  input  axil_data_t                   req_data,
  input  axil_strb_t                   req_strb,
  output logic                         req_ready,

  output logic                         s_axil_bvalid,
  output axil_resp_t                   s_axil_bresp,
  input  logic                         s_axil_bready,

  output logic       [NUM_S-1:0]       m_axil_awvalid,
  output sub_addr_t  [NUM_S-1:0]       m_axil_awaddr,
  input  logic       [NUM_S-1:0]       m_axil_awready,

  output logic       [NUM_S-1:0]       m_axil_wvalid,
  output axil_data_t [NUM_S-1:0]       m_axil_wdata,
  output axil_strb_t [NUM_S-1:0]       m_axil_wstrb,
  input  logic       [NUM_S-1:0]       m_axil_wready,

  input  logic       [NUM_S-1:0]       m_axil_bvalid,
  input  axil_resp_t [NUM_S-1:0]       m_axil_bresp,
  output logic       [NUM_S-1:0]       m_axil_bready
);

  typedef enum logic [1:0] {
    state_idle,
    state_issue,
    state_wait_b,
    state_respond
  } state_t;

  state_t           state;
  logic [SEL_W-1:0] sel_q;
  sub_addr_t        addr_q;
  axil_data_t       data_q;
  axil_strb_t       strb_q;
  axil_resp_t       resp_q;
  logic             aw_done;
  logic             w_done;
  logic             req_unmapped;
  logic             aw_hs;
  logic             w_hs;
  logic             sel_bvalid;
  axil_resp_t       sel_bresp;

  // Select values from NUM_S upwards have no bank behind them
  assign req_unmapped = 32'(req_addr[ADDR_W-1 -: SEL_W]) >= NUM_S;

  assign req_ready     = (state == state_idle);
  assign s_axil_bvalid = (state == state_respond);
  assign s_axil_bresp  = resp_q;

  // Only the selected bank can raise a valid, so an OR of all lanes is enough
  assign aw_hs = |(m_axil_awvalid & m_axil_awready);
  assign w_hs  = |(m_axil_wvalid & m_axil_wready);

  always_comb begin
    sel_bvalid = 1'b0;
    sel_bresp  = RESP_OKAY;
    for (int b = 0; b < NUM_S; b++) begin
      m_axil_awvalid[b] = (state == state_issue) && (sel_q == SEL_W'(b)) && !aw_done;
      m_axil_wvalid[b]  = (state == state_issue) && (sel_q == SEL_W'(b)) && !w_done;
      m_axil_bready[b]  = (state == state_wait_b) && (sel_q == SEL_W'(b));
      m_axil_awaddr[b]  = addr_q;
      m_axil_wdata[b]   = data_q;
      m_axil_wstrb[b]   = strb_q;
      if (sel_q == SEL_W'(b)) begin
        sel_bvalid = m_axil_bvalid[b];
        sel_bresp  = m_axil_bresp[b];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= state_idle;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        state_idle: begin
          if (req_valid) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            state   <= req_unmapped ? state_respond : state_issue;
          end
        end
        state_issue: begin
          if (aw_hs) begin
            aw_done <= 1'b1;
          end
          if (w_hs) begin
            w_done <= 1'b1;
          end
          // Both beats may complete in the same cycle or in either order
          if ((aw_done || aw_hs) && (w_done || w_hs)) begin
            state <= state_wait_b;
          end
        end
        state_wait_b: begin
          if (sel_bvalid) begin
            state <= state_respond;
          end
        end
        state_respond: begin
          if (s_axil_bready) begin
            state <= state_idle;
          end
        end
        default: state <= state_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == state_idle && req_valid) begin
      sel_q  <= req_addr[ADDR_W-1 -: SEL_W];
      addr_q <= req_addr[ADDR_W-SEL_W-1:0];
      data_q <= req_data;
      strb_q <= req_strb;
      resp_q <= RESP_DECERR;
    end else if (state == state_wait_b && sel_bvalid) begin
      resp_q <= sel_bresp;
    end
  end

endmodule

// ==== common/axil_pkg.sv ====
package axil_pkg;

  // Upstream byte address width
  localparam int ADDR_W = 16;

  // Data width, the same upstream and toward every bank
  localparam int DATA_W = 32;

  // Bank select field taken from the top of the address
  localparam int SEL_W = 2;

  typedef logic [ADDR_W-1:0] axil_addr_t;

  // Address as seen by a bank, with the select bits stripped
  typedef logic [ADDR_W-SEL_W-1:0] sub_addr_t;

  typedef logic [DATA_W-1:0] axil_data_t;

  typedef logic [DATA_W/8-1:0] axil_strb_t;

  typedef logic [1:0] axil_resp_t;

  localparam axil_resp_t RESP_OKAY = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;
  localparam axil_resp_t RESP_DECERR = 2'b11;

endpackage

// ==== src/axil_reg_bank.sv ====
`timescale 1ns/1ps

module axil_reg_bank
  import axil_pkg::*;
#(
  parameter int REG_COUNT = 4
) (
  input  logic                           clk,
  input  logic                           rst_n,

  input  logic                           awvalid,
  input  sub_addr_t                      awaddr,
  output logic                           awready,

  input  logic                           wvalid,
  input  axil_data_t                     wdata,
  input  axil_strb_t                     wstrb,
  output logic                           wready,

  output logic                           bvalid,
  output axil_resp_t                     bresp,
  input  logic                           bready,

  output axil_data_t [REG_COUNT-1:0]     cfg_regs
);

  // Word index width inside the bank-local byte address
  localparam int IDX_W = ADDR_W - SEL_W - 2;

  logic             wr_fire;
  logic             in_range;
  logic [IDX_W-1:0] word_idx;

  // Both beats are taken together, and only while no response is pending
  assign wr_fire = awvalid & wvalid & ~bvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;

  assign word_idx = awaddr[ADDR_W-SEL_W-1:2];
  assign in_range = 32'(awaddr) < 32'(REG_COUNT * 4);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid   <= 1'b0;
      cfg_regs <= '0;
    end else begin
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end

      if (wr_fire && in_range) begin
        for (int r = 0; r < REG_COUNT; r++) begin
          if (word_idx == IDX_W'(r)) begin
            for (int i = 0; i < DATA_W / 8; i++) begin
              if (wstrb[i]) begin
                cfg_regs[r][i*8 +: 8] <= wdata[i*8 +: 8];
              end
            end
          end
        end
      end
    end
  end

  // Out of range writes change nothing and get SLVERR
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

// ==== src/axil_wr_subsystem.sv ====
`timescale 1ns/1ps

module axil_wr_subsystem
  import axil_pkg::*;
#(
  parameter int NUM_S     = 3,
  parameter int REG_COUNT = 4
) (
  input  logic                                 clk,
  input  logic                                 rst_n,

  input  logic                                 s_axil_awvalid,
  input  axil_addr_t                           s_axil_awaddr,
  output logic                                 s_axil_awready,

  input  logic                                 s_axil_wvalid,
  input  axil_data_t                           s_axil_wdata,
  input  axil_strb_t                           s_axil_wstrb,
  output logic                                 s_axil_wready,

  output logic                                 s_axil_bvalid,
  output axil_resp_t                           s_axil_bresp,
  input  logic                                 s_axil_bready,

  output axil_data_t [NUM_S*REG_COUNT-1:0]     cfg_regs
);

  logic       req_valid;
  axil_addr_t req_addr;
  axil_data_t req_data;
  axil_strb_t req_strb;
  logic       req_ready;

  logic       [NUM_S-1:0] bank_awvalid;
  sub_addr_t  [NUM_S-1:0] bank_awaddr;
  logic       [NUM_S-1:0] bank_awready;
  logic       [NUM_S-1:0] bank_wvalid;
  axil_data_t [NUM_S-1:0] bank_wdata;
  axil_strb_t [NUM_S-1:0] bank_wstrb;
  logic       [NUM_S-1:0] bank_wready;
  logic       [NUM_S-1:0] bank_bvalid;
  axil_resp_t [NUM_S-1:0] bank_bresp;
  logic       [NUM_S-1:0] bank_bready;

  axil_wr_join u_axil_wr_join (
    .clk            (clk),
    .rst_n          (rst_n),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awready (s_axil_awready),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wready  (s_axil_wready),
    .req_valid      (req_valid),
    .req_addr       (req_addr),
    .req_data       (req_data),
    .req_strb       (req_strb),
    .req_ready      (req_ready)
  );

  axil_wr_router #(
    .NUM_S (NUM_S)
  ) u_axil_wr_router (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid      (req_valid),
    .req_addr       (req_addr),
    .req_data       (req_data),
    .req_strb       (req_strb),
    .req_ready      (req_ready),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bready  (s_axil_bready),
    .m_axil_awvalid (bank_awvalid),
    .m_axil_awaddr  (bank_awaddr),
    .m_axil_awready (bank_awready),
    .m_axil_wvalid  (bank_wvalid),
    .m_axil_wdata   (bank_wdata),
    .m_axil_wstrb   (bank_wstrb),
    .m_axil_wready  (bank_wready),
    .m_axil_bvalid  (bank_bvalid),
    .m_axil_bresp   (bank_bresp),
    .m_axil_bready  (bank_bready)
  );

  // Bank b owns words b*REG_COUNT up to b*REG_COUNT+REG_COUNT-1 of cfg_regs
  for (genvar b = 0; b < NUM_S; b++) begin : g_bank
    axil_reg_bank #(
      .REG_COUNT (REG_COUNT)
    ) u_axil_reg_bank (
      .clk      (clk),
      .rst_n    (rst_n),
      .awvalid  (bank_awvalid[b]),
      .awaddr   (bank_awaddr[b]),
      .awready  (bank_awready[b]),
      .wvalid   (bank_wvalid[b]),
      .wdata    (bank_wdata[b]),
      .wstrb    (bank_wstrb[b]),
      .wready   (bank_wready[b]),
      .bvalid   (bank_bvalid[b]),
      .bresp    (bank_bresp[b]),
      .bready   (bank_bready[b]),
      .cfg_regs (cfg_regs[b*REG_COUNT +: REG_COUNT])
    );
  end

endmodule

// ==== tb.f ====
common/axil_pkg.sv
axil_wr_router/axil_wr_join.sv
axil_wr_router/axil_wr_router.sv
src/axil_reg_bank.sv
src/axil_wr_subsystem.sv
tb/tb_clk_gen.sv
tb/axil_wr_router_properties.sv
tb/axil_wr_subsystem_tb.sv

// ==== tb/axil_wr_router_properties.sv ====
`timescale 1ns/1ps

module axil_wr_router_properties
  import axil_pkg::*;
#(
  parameter int NUM_S = 3
) (
  input logic             clk,
  input logic             rst_n,
  input logic             s_axil_bvalid,
  input axil_resp_t       s_axil_bresp,
  input logic             s_axil_bready,
  input logic [NUM_S-1:0] m_axil_awvalid,
  input logic [NUM_S-1:0] m_axil_wvalid,
  input logic [NUM_S-1:0] m_axil_bvalid
);

  // The upstream response stays up with the same code until it is taken
  assert property (@(posedge clk) disable iff (!rst_n)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp))
    else $error("s_axil_bvalid dropped or s_axil_bresp changed before s_axil_bready");

  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(m_axil_awvalid))
    else $error("more than one bank sees awvalid");

  // Bank side is quiet while the upstream response is pending
  assert property (@(posedge clk) disable iff (!rst_n)
    s_axil_bvalid |-> !(|m_axil_awvalid) && !(|m_axil_wvalid) && !(|m_axil_bvalid))
    else $error("bank side valid high while s_axil_bvalid is high");

endmodule

bind axil_wr_router axil_wr_router_properties #(
  .NUM_S (NUM_S)
) u_axil_wr_router_properties (
  .clk            (clk),
  .rst_n          (rst_n),
  .s_axil_bvalid  (s_axil_bvalid),
  .s_axil_bresp   (s_axil_bresp),
  .s_axil_bready  (s_axil_bready),
  .m_axil_awvalid (m_axil_awvalid),
  .m_axil_wvalid  (m_axil_wvalid),
  .m_axil_bvalid  (m_axil_bvalid)
);

// ==== tb/axil_wr_subsystem_tb.sv ====
`timescale 1ns/1ps

module axil_wr_subsystem_tb
  import axil_pkg::*;
();

  localparam int NUM_S = 3;
  localparam int REG_COUNT = 4;
  localparam int NUM_WORDS = NUM_S * REG_COUNT;
  localparam int NUM_RANDOM = 150;
  // About 200 writes at up to 20 cycles each, with margin
  localparam int MAX_CYCLES = 5000;

  logic       clk;
  logic       rst_n;
  logic       s_axil_awvalid;
  axil_addr_t s_axil_awaddr;
  logic       s_axil_awready;
  logic       s_axil_wvalid;
  axil_data_t s_axil_wdata;
  axil_strb_t s_axil_wstrb;
  logic       s_axil_wready;
  logic       s_axil_bvalid;
  axil_resp_t s_axil_bresp;
  logic       s_axil_bready;
  axil_data_t [NUM_WORDS-1:0] cfg_regs;

  axil_data_t [NUM_WORDS-1:0] model;
  axil_addr_t pend_addr[$];
  axil_data_t pend_data[$];
  axil_strb_t pend_strb[$];
  axil_resp_t exp_resp;
  axil_addr_t cur_addr;
  axil_data_t cur_data;
  axil_strb_t cur_strb;
  int seed = 77898;
  int errors = 0;
  int checks = 0;
  int issued = 0;
  int completed = 0;
  int cycle_count = 0;
  int bready_left = 0;
  logic bready_random = 1'b0;
  int kind;
  int sel;
  int offset;

  tb_clk_gen u_tb_clk_gen (
    .clk (clk)
  );

  axil_wr_subsystem #(
    .NUM_S     (NUM_S),
    .REG_COUNT (REG_COUNT)
  ) u_axil_wr_subsystem (
    .clk            (clk),
    .rst_n          (rst_n),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awready (s_axil_awready),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bready  (s_axil_bready),
    .cfg_regs       (cfg_regs)
  );

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Expected response of one write, merging it into the register model when it is accepted
  function automatic axil_resp_t expected_write(input axil_addr_t addr, input axil_data_t data,
                                                input axil_strb_t strb,
                                                inout axil_data_t [NUM_WORDS-1:0] regs);
    int unsigned bank;
    int unsigned local_addr;
    int unsigned word;
    bank = 32'(addr[ADDR_W-1 -: SEL_W]);
    local_addr = 32'(addr[ADDR_W-SEL_W-1:0]);
    if (bank >= 32'(NUM_S)) begin
      return RESP_DECERR;
    end
    if (local_addr >= 32'(4 * REG_COUNT)) begin
      return RESP_SLVERR;
    end
    word = bank * 32'(REG_COUNT) + local_addr / 4;
    for (int i = 0; i < DATA_W / 8; i++) begin
      if (strb[i]) begin
        regs[word][i*8 +: 8] = data[i*8 +: 8];
      end
    end
    return RESP_OKAY;
  endfunction

  // Called on a falling edge, returns on the falling edge after the handshake
  task automatic send_aw(input axil_addr_t addr);
    logic taken;
    s_axil_awvalid = 1'b1;
    s_axil_awaddr  = addr;
    taken = 1'b0;
    while (!taken) begin
      taken = s_axil_awready;
      @(negedge clk);
    end
    s_axil_awvalid = 1'b0;
  endtask

  task automatic send_w(input axil_data_t data, input axil_strb_t strb);
    logic taken;
    s_axil_wvalid = 1'b1;
    s_axil_wdata  = data;
    s_axil_wstrb  = strb;
    taken = 1'b0;
    while (!taken) begin
      taken = s_axil_wready;
      @(negedge clk);
    end
    s_axil_wvalid = 1'b0;
  endtask

  // Order 0 sends AW first, 1 sends W first, anything else sends both together
  task automatic do_write(input axil_addr_t addr, input axil_data_t data,
                          input axil_strb_t strb, input int order);
    pend_addr.push_back(addr);
    pend_data.push_back(data);
    pend_strb.push_back(strb);
    issued++;
    case (order)
      0: begin
        send_aw(addr);
        send_w(data, strb);
      end
      1: begin
        send_w(data, strb);
        send_aw(addr);
      end
      default: begin
        fork
          send_aw(addr);
          send_w(data, strb);
        join
      end
    endcase
  endtask

  function automatic axil_addr_t make_addr(input int bank, input int local_addr);
    return axil_addr_t'((bank << (ADDR_W - SEL_W)) | local_addr);
  endfunction

  // Every upstream B handshake is checked against the model
  always @(posedge clk) begin
    if (rst_n && s_axil_bvalid && s_axil_bready) begin
      if (pend_addr.size() == 0) begin
        errors++;
        $display("Write response at %0t ns with no write outstanding", $time);
      end else begin
        cur_addr = pend_addr.pop_front();
        cur_data = pend_data.pop_front();
        cur_strb = pend_strb.pop_front();
        exp_resp = expected_write(cur_addr, cur_data, cur_strb, model);
        check($sformatf("bresp for address %h", cur_addr), 32'(s_axil_bresp), 32'(exp_resp));
        for (int w = 0; w < NUM_WORDS; w++) begin
          check($sformatf("cfg_regs word %0d", w), cfg_regs[w], model[w]);
        end
        completed++;
      end
    end
  end

  always @(negedge clk) begin
    if (!bready_random) begin
      s_axil_bready = 1'b1;
    end else if (bready_left == 0) begin
      s_axil_bready = ~s_axil_bready;
      bready_left = 1 + int'($unsigned($random(seed)) % 6);
    end else begin
      bready_left--;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    rst_n = 1'b0;
    s_axil_awvalid = 1'b0;
    s_axil_awaddr = '0;
    s_axil_wvalid = 1'b0;
    s_axil_wdata = '0;
    s_axil_wstrb = '0;
    s_axil_bready = 1'b1;
    model = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    check("s_axil_bvalid after reset", 32'(s_axil_bvalid), 32'd0);
    check("s_axil_awready after reset", 32'(s_axil_awready), 32'd1);
    check("s_axil_wready after reset", 32'(s_axil_wready), 32'd1);
    for (int w = 0; w < NUM_WORDS; w++) begin
      check($sformatf("cfg_regs word %0d after reset", w), cfg_regs[w], 32'd0);
    end

    for (int b = 0; b < NUM_S; b++) begin
      for (int r = 0; r < REG_COUNT; r++) begin
        do_write(make_addr(b, r * 4), $random(seed), 4'hf, (b * REG_COUNT + r) % 3);
      end
    end

    // Partial strobes, including an empty one
    do_write(make_addr(0, 4), 32'h1234_5678, 4'b0101, 0);
    do_write(make_addr(2, 12), 32'hdead_beef, 4'b1000, 1);
    do_write(make_addr(1, 8), 32'hcafe_f00d, 4'b0000, 2);

    do_write(make_addr(1, 4 * REG_COUNT), 32'hffff_ffff, 4'hf, 0);
    do_write(make_addr(0, 16'h3ffc), 32'hffff_ffff, 4'hf, 2);
    do_write(make_addr(3, 0), 32'haaaa_aaaa, 4'hf, 1);
    do_write(make_addr(3, 4), 32'h5555_5555, 4'hf, 2);

    bready_random = 1'b1;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      kind = int'($unsigned($random(seed)) % 8);
      sel = int'($unsigned($random(seed)) % NUM_S);
      if (kind == 0) begin
        sel = 3;
        offset = int'($unsigned($random(seed)) % 16384);
      end else if (kind == 1) begin
        offset = 4 * REG_COUNT + int'($unsigned($random(seed)) % (16384 - 4 * REG_COUNT));
      end else begin
        offset = int'($unsigned($random(seed)) % (4 * REG_COUNT));
      end
      do_write(make_addr(sel, offset), $random(seed), axil_strb_t'($random(seed)),
               int'($unsigned($random(seed)) % 3));
      repeat (int'($unsigned($random(seed)) % 4)) @(negedge clk);
    end

    while (completed != issued) begin
      @(negedge clk);
    end
    bready_random = 1'b0;
    repeat (5) @(negedge clk);
    // With every write answered the upstream port is back to idle
    check("s_axil_bvalid after the last response", 32'(s_axil_bvalid), 32'd0);
    check("s_axil_awready after the last response", 32'(s_axil_awready), 32'd1);
    check("s_axil_wready after the last response", 32'(s_axil_wready), 32'd1);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD_NS = 10
) (
  output logic clk
);

  // A 20 ns period with the default half period
  initial begin
    clk = 1'b0;
  end

  always begin
    #(HALF_PERIOD_NS);
    clk = ~clk;
  end

endmodule
